/* compile.f */
hdl/rv_decode_pkg.sv
hdl/instr_queue.sv
hdl/decode.sv
hdl/reg_read.sv
hdl/rv_frontend_top.sv
tb/rv_frontend_checker.sv
tb/rv_frontend_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the frontend testbench with Verilator, run it, then scan the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module rv_frontend_tb \
    -f compile.f -o rv_frontend_sim > build.log 2>&1 &&
./obj_dir/rv_frontend_sim > sim.log 2>&1 ||
echo "Result: FAILED" >> sim.log
cat sim.log
grep -q "%Error" sim.log && echo "Result: FAILED" >> sim.log
! grep -q "Result: FAILED" sim.log

/* tb/rv_frontend_tb.sv */
`default_nettype none

module rv_frontend_tb
    import rv_decode_pkg::*;
();

    localparam int QUEUE_DEPTH = 4;
    localparam int N_R  = 40;
    localparam int N_I  = 40;
    localparam int N_X  = 27;
    localparam int N_BP = 40;
    // preload writes included
    localparam int N_ALL = 32 + N_R + N_I + N_X + 2 * (QUEUE_DEPTH + 2) + N_BP + 12;
    localparam int WATCHDOG_CYCLES = N_ALL * (QUEUE_DEPTH + 10) + 200;

    typedef struct packed {
        t_uop        uop;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [31:0] src1;
        logic [31:0] src2;
        logic [31:0] t_acc;
    } t_expected;

    logic                  clk;
    logic                  reset;
    logic                  in_valid;
    t_rv_instr             in_instr;
    logic                  in_ready;
    logic                  ex_valid;
    t_uop                  ex_uop;
    logic [REG_ADDR_W-1:0] ex_rd;
    logic [31:0]           ex_src1;
    logic [31:0]           ex_src2;
    logic [2:0]            ex_funct3;
    logic                  ex_ready;
    logic                  wb_valid;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [31:0]           wb_data;

    logic [31:0] shadow [32];
    t_expected   exp_q [$];
    int          cycle;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    int          ops_taken;
    string       test_name;
    logic        check_latency;
    logic        random_ready;

    rv_frontend_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_dut (
        .clk, .reset, .in_valid, .in_instr, .in_ready,
        .ex_valid, .ex_uop, .ex_rd, .ex_src1, .ex_src2, .ex_funct3, .ex_ready,
        .wb_valid, .wb_rd, .wb_data
    );

    always #2 clk = ~clk;

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAIL %s %s expected %h actual %h", test_name, what, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR %s: %s", test_name, msg);
        errors++;
        test_errors++;
    endtask

    // expected tuple straight from the RV32I encoding rules
    function automatic t_expected expect_op(input t_rv_instr w);
        t_expected   e;
        logic [31:0] b;
        logic        is_op;
        b = w;
        is_op = (b[6:0] == 7'b0110011);
        e = '0;
        e.uop = ILLEGAL;
        if ((is_op && (b[31:25] == 7'b0000000 || b[31:25] == 7'b0100000))
                || b[6:0] == 7'b0010011) begin
            case (b[14:12])
                3'd0:    e.uop = (is_op && b[30]) ? SUB : ADD;
                3'd1:    e.uop = SLL;
                3'd2:    e.uop = SLT;
                3'd3:    e.uop = SLTU;
                3'd4:    e.uop = XOR;
                3'd5:    e.uop = b[30] ? SRA : SRL;
                3'd6:    e.uop = OR;
                default: e.uop = AND;
            endcase
            e.funct3 = b[14:12];
            e.rd     = b[11:7];
            e.src1   = shadow[b[19:15]];
            e.src2   = is_op ? shadow[b[24:20]] : {{20{b[31]}}, b[31:20]};
        end
        return e;
    endfunction

    // reference model and scoreboard
    always @(posedge clk) begin
        t_expected e;
        if (reset) begin
            exp_q.delete();
        end else begin
            assert (exp_q.size() <= QUEUE_DEPTH + 2)
                else report_error("more instructions in flight than the pipeline holds");
            if (exp_q.size() == QUEUE_DEPTH + 2) begin
                assert (!in_ready) else report_error("in_ready high with the pipeline full");
            end
            if (ex_valid && ex_ready) begin
                assert (exp_q.size() != 0) else report_error("operation with none pending");
                if (exp_q.size() != 0) begin
                    e = exp_q.pop_front();
                    ops_taken++;
                    check_value("uop", 32'(e.uop), 32'(ex_uop));
                    check_value("funct3", 32'(e.funct3), 32'(ex_funct3));
                    check_value("rd", 32'(e.rd), 32'(ex_rd));
                    check_value("src1", e.src1, ex_src1);
                    check_value("src2", e.src2, ex_src2);
                    if (check_latency) begin
                        check_value("latency", 32'd3, cycle - e.t_acc);
                    end
                end
            end
            if (in_valid && in_ready) begin
                e = expect_op(in_instr);
                e.t_acc = cycle;
                exp_q.push_back(e);
            end
        end
        if (wb_valid && wb_rd != '0) begin
            shadow[wb_rd] = wb_data;
        end
        cycle++;
    end

    task automatic step();
        @(posedge clk);
        #1;
        if (random_ready) begin
            ex_ready = ($urandom_range(2, 0) != 0);
        end
    endtask

    task automatic send(input t_rv_instr instr);
        logic ok;
        in_valid = 1'b1;
        in_instr = instr;
        do begin
            @(negedge clk);
            ok = in_ready;
            step();
        end while (!ok);
        in_valid = 1'b0;
    endtask

    task automatic write_reg(input logic [4:0] idx, input logic [31:0] data);
        wb_valid = 1'b1;
        wb_rd    = idx;
        wb_data  = data;
        step();
        wb_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            step();
        end
        // room for any duplicate to show up
        repeat (4) step();
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
        ops_taken   = 0;
    endtask

    task automatic end_test();
        drain();
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %s: %0d ops taken, %0d errors", test_name, ops_taken, test_errors);
    endtask

    function automatic t_rv_instr random_r();
        t_rv_instr   w;
        logic [31:0] raw;
        raw = $urandom;
        w = raw;
        w.r.opcode = OP;
        // alternate encoding only where it selects SUB or SRA
        if (w.r.funct3 == 3'b000 || w.r.funct3 == 3'b101) begin
            w.r.funct7 = {1'b0, raw[30], 5'b0};
        end else begin
            w.r.funct7 = '0;
        end
        return w;
    endfunction

    function automatic t_rv_instr random_i(input logic negative);
        t_rv_instr   w;
        logic [31:0] raw;
        raw = $urandom;
        w = raw;
        w.i.opcode = OP_IMM;
        w.i.imm_11_0[11] = negative;
        if (w.i.funct3 == 3'b101) begin
            w.i.imm_11_0[11:5] = {1'b0, raw[0], 5'b0};
        end else if (w.i.funct3 == 3'b001) begin
            w.i.imm_11_0[11:5] = '0;
        end
        return w;
    endfunction

    function automatic t_rv_instr unsupported_op(input int sel);
        t_rv_instr   w;
        logic [31:0] raw;
        raw = $urandom;
        w = raw;
        case (sel)
            0: w.r.opcode = LOAD;
            1: w.r.opcode = STORE;
            2: w.r.opcode = BRANCH;
            3: w.r.opcode = LUI;
            4: w.r.opcode = JAL;
            5: w.r.opcode = JALR;
            6: w.r.opcode = AUIPC;
            7: w.r.opcode = t_rv_opcode'(7'b1111111);
            default: begin
                // OP with a funct7 outside the base set
                w.r.opcode = OP;
                w.r.funct7 = 7'b0000001;
            end
        endcase
        return w;
    endfunction

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        t_rv_instr   w;
        t_expected   e;
        logic [31:0] data;
        int          i;
        clk = 1'b0;
        reset = 1'b1;
        in_valid = 1'b0;
        in_instr = '0;
        ex_ready = 1'b1;
        wb_valid = 1'b0;
        wb_rd = '0;
        wb_data = '0;
        check_latency = 1'b0;
        random_ready = 1'b0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        cycle = 0;
        test_name = "init";
        for (i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        void'($urandom(32'hc4ed));
        repeat (3) step();
        reset = 1'b0;

        begin_test("r_format");
        for (i = 0; i < 32; i++) begin
            write_reg(5'(i), $urandom);
        end
        check_latency = 1'b1;
        for (i = 0; i < N_R; i++) begin
            send(random_r());
        end
        end_test();
        check_latency = 1'b0;

        begin_test("i_format");
        for (i = 0; i < N_I; i++) begin
            send(random_i(i[0]));
        end
        end_test();

        begin_test("unsupported");
        for (i = 0; i < N_X; i++) begin
            send(unsupported_op(i % 9));
        end
        end_test();

        begin_test("backpressure");
        ex_ready = 1'b0;
        for (i = 0; i < QUEUE_DEPTH + 2; i++) begin
            send(random_r());
        end
        @(negedge clk);
        assert (!in_ready) else report_error("in_ready still high with the pipeline full");
        step();
        random_ready = 1'b1;
        for (i = 0; i < N_BP; i++) begin
            if (i[0]) begin
                send(random_r());
            end else begin
                send(random_i(i[1]));
            end
        end
        drain();
        random_ready = 1'b0;
        ex_ready = 1'b1;
        end_test();

        begin_test("x0_bypass");
        write_reg(5'd0, $urandom | 32'h1);
        w = random_r();
        w.r.rs1 = '0;
        w.r.rs2 = '0;
        send(w);
        w = random_i(1'b1);
        w.i.rs1 = '0;
        send(w);
        drain();
        data = ~shadow[9];
        w = random_r();
        w.r.rs1 = 5'd9;
        w.r.rs2 = 5'd9;
        send(w);
        step();
        // instruction sits in RD0 now, writeback lands in the same cycle
        wb_valid = 1'b1;
        wb_rd = 5'd9;
        wb_data = data;
        e = exp_q.pop_back();
        e.src1 = data;
        e.src2 = data;
        exp_q.push_back(e);
        step();
        wb_valid = 1'b0;
        end_test();

        begin_test("reset");
        ex_ready = 1'b0;
        for (i = 0; i < QUEUE_DEPTH + 2; i++) begin
            send(random_r());
        end
        reset = 1'b1;
        repeat (3) step();
        reset = 1'b0;
        ex_ready = 1'b1;
        @(negedge clk);
        assert (!ex_valid && in_ready && !i_dut.fe_valid_de0)
            else report_error("pipeline not empty after reset");
        step();
        for (i = 0; i < 4; i++) begin
            send(random_i(i[0]));
        end
        end_test();

        $display("summary: %0d tests, %0d failed, %0d check errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/rv_frontend_checker.sv */
`default_nettype none

module rv_frontend_checker
    import rv_decode_pkg::*;
(
    input logic                  clk,
    input logic                  reset,
    input logic                  in_ready,
    input logic                  fe_valid_de0,
    input logic                  stall,
    input logic                  valid_rd0,
    input logic                  ex_valid,
    input logic                  ex_ready,
    input t_uop                  ex_uop,
    input logic [REG_ADDR_W-1:0] ex_rd,
    input logic [2:0]            ex_funct3,
    input logic [31:0]           ex_src1,
    input logic [31:0]           ex_src2
);

    // pipeline comes out of reset empty
    a_empty_after_reset: assert property (@(posedge clk) reset |=> !ex_valid && !valid_rd0)
        else $error("valid operation in the cycle after reset");

    // a held operation stays unchanged until execute takes it
    a_ex_hold: assert property (@(posedge clk) disable iff (reset)
        ex_valid && !ex_ready |=> ex_valid && $stable(ex_uop) && $stable(ex_rd)
            && $stable(ex_funct3) && $stable(ex_src1) && $stable(ex_src2))
        else $error("execute outputs changed under back-pressure");

    // full queue with no pop must stay full
    a_no_push_when_full: assert property (@(posedge clk) disable iff (reset)
        !in_ready && (!fe_valid_de0 || stall) |=> !in_ready)
        else $error("queue accepted a word while full");

endmodule

bind rv_frontend_top rv_frontend_checker i_checker (
    .clk(clk), .reset(reset), .in_ready(in_ready), .fe_valid_de0(fe_valid_de0),
    .stall(stall), .valid_rd0(valid_rd0), .ex_valid(ex_valid), .ex_ready(ex_ready),
    .ex_uop(ex_uop), .ex_rd(ex_rd), .ex_funct3(ex_funct3),
    .ex_src1(ex_src1), .ex_src2(ex_src2)
);

`default_nettype wire

/* hdl/rv_frontend_top.sv */
`default_nettype none

module rv_frontend_top
    import rv_decode_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  in_valid,
    input  t_rv_instr             in_instr,
    output logic                  in_ready,

    output logic                  ex_valid,
    output t_uop                  ex_uop,
    output logic [REG_ADDR_W-1:0] ex_rd,
    output logic [31:0]           ex_src1,
    output logic [31:0]           ex_src2,
    output logic [2:0]            ex_funct3,
    input  logic                  ex_ready,

    input  logic                  wb_valid,
    input  logic [REG_ADDR_W-1:0] wb_rd,
    input  logic [31:0]           wb_data
);

    logic                  stall;
    logic                  fe_valid_de0;
    t_rv_instr             instr_de0;

    // micro-instruction between decode and register read
    logic                  valid_rd0;
    t_uop                  uop_rd0;
    t_rv_instr_format      ifmt_rd0;
    logic [2:0]            funct3_rd0;
    logic [REG_ADDR_W-1:0] rd_rd0;
    logic [REG_ADDR_W-1:0] rs1_rd0;
    logic [REG_ADDR_W-1:0] rs2_rd0;
    logic                  src2_is_imm_rd0;
    logic [31:0]           imm32_rd0;

    instr_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_queue (
        .clk, .reset, .in_valid, .in_instr, .in_ready,
        .stall, .fe_valid_de0, .instr_de0
    );

    decode i_decode (
        .clk, .reset, .stall, .fe_valid_de0, .instr_de0,
        .valid_rd0, .uop_rd0, .ifmt_rd0, .funct3_rd0, .rd_rd0,
        .rs1_rd0, .rs2_rd0, .src2_is_imm_rd0, .imm32_rd0
    );

    reg_read i_reg_read (
        .clk, .reset,
        .valid_rd0, .uop_rd0, .ifmt_rd0, .funct3_rd0, .rd_rd0,
        .rs1_rd0, .rs2_rd0, .src2_is_imm_rd0, .imm32_rd0,
        .wb_valid, .wb_rd, .wb_data, .ex_ready,
        .stall, .ex_valid, .ex_uop, .ex_rd, .ex_funct3, .ex_src1, .ex_src2
    );

endmodule

`default_nettype wire

/* hdl/reg_read.sv */
`default_nettype none

module reg_read
    import rv_decode_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  valid_rd0,
    input  t_uop                  uop_rd0,
    input  t_rv_instr_format      ifmt_rd0,
    input  logic [2:0]            funct3_rd0,
    input  logic [REG_ADDR_W-1:0] rd_rd0,
    input  logic [REG_ADDR_W-1:0] rs1_rd0,
    input  logic [REG_ADDR_W-1:0] rs2_rd0,
    input  logic                  src2_is_imm_rd0,
    input  logic [31:0]           imm32_rd0,

    input  logic                  wb_valid,
    input  logic [REG_ADDR_W-1:0] wb_rd,
    input  logic [31:0]           wb_data,
    input  logic                  ex_ready,

    output logic                  stall,
    output logic                  ex_valid,
    output t_uop                  ex_uop,
    output logic [REG_ADDR_W-1:0] ex_rd,
    output logic [2:0]            ex_funct3,
    output logic [31:0]           ex_src1,
    output logic [31:0]           ex_src2
);

    // x0 is not stored
    logic [31:0] rf [1:31];
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] src1_rd0;
    logic [31:0] src2_rd0;

    always_comb stall = ex_valid & ~ex_ready;

    always_ff @(posedge clk) begin
        if (wb_valid && wb_rd != '0) begin
            rf[wb_rd] <= wb_data;
        end
    end

    // read ports, a writeback in the same cycle wins
    always_comb begin
        if (rs1_rd0 == '0) begin
            rs1_val = '0;
        end else if (wb_valid && wb_rd == rs1_rd0) begin
            rs1_val = wb_data;
        end else begin
            rs1_val = rf[rs1_rd0];
        end
    end

    always_comb begin
        if (rs2_rd0 == '0) begin
            rs2_val = '0;
        end else if (wb_valid && wb_rd == rs2_rd0) begin
            rs2_val = wb_data;
        end else begin
            rs2_val = rf[rs2_rd0];
        end
    end

    // operand select by format
    always_comb begin
        src1_rd0 = '0;
        src2_rd0 = '0;
        if (ifmt_rd0 == FMT_R || ifmt_rd0 == FMT_I) begin
            src1_rd0 = rs1_val;
        end
        if (src2_is_imm_rd0) begin
            src2_rd0 = imm32_rd0;
        end else if (ifmt_rd0 == FMT_R) begin
            src2_rd0 = rs2_val;
        end
    end

    // output stage, held under back-pressure
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else if (!stall) begin
            ex_valid <= valid_rd0;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ex_uop    <= uop_rd0;
            ex_rd     <= rd_rd0;
            ex_funct3 <= funct3_rd0;
            ex_src1   <= src1_rd0;
            ex_src2   <= src2_rd0;
        end
    end

endmodule

`default_nettype wire

/* hdl/decode.sv */
`default_nettype none

module decode
    import rv_decode_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  fe_valid_de0,
    input  t_rv_instr             instr_de0,

    output logic                  valid_rd0,
    output t_uop                  uop_rd0,
    output t_rv_instr_format      ifmt_rd0,
    output logic [2:0]            funct3_rd0,
    output logic [REG_ADDR_W-1:0] rd_rd0,
    output logic [REG_ADDR_W-1:0] rs1_rd0,
    output logic [REG_ADDR_W-1:0] rs2_rd0,
    output logic                  src2_is_imm_rd0,
    output logic [31:0]           imm32_rd0
);

    // DE0 nets
    t_rv_instr_format      ifmt_de0;
    t_uop                  uop_de0;
    logic [2:0]            funct3_de0;
    logic [REG_ADDR_W-1:0] rd_de0;
    logic [REG_ADDR_W-1:0] rs1_de0;
    logic [REG_ADDR_W-1:0] rs2_de0;
    logic                  src2_is_imm_de0;
    logic [31:0]           imm32_de0;

    always_comb ifmt_de0 = get_instr_format(instr_de0.r.opcode);
    always_comb uop_de0  = rv_instr_to_uop(instr_de0);

    // operand extraction
    always_comb begin
        funct3_de0      = '0;
        rd_de0          = '0;
        rs1_de0         = '0;
        rs2_de0         = '0;
        src2_is_imm_de0 = 1'b0;
        imm32_de0       = '0;

        // illegal ops carry no operands, even if the format is R or I
        if (uop_de0 != ILLEGAL) begin
            case (ifmt_de0)
                FMT_R: begin
                    funct3_de0 = instr_de0.r.funct3;
                    rd_de0     = instr_de0.r.rd;
                    rs1_de0    = instr_de0.r.rs1;
                    rs2_de0    = instr_de0.r.rs2;
                end
                FMT_I: begin
                    funct3_de0      = instr_de0.i.funct3;
                    rd_de0          = instr_de0.i.rd;
                    rs1_de0         = instr_de0.i.rs1;
                    src2_is_imm_de0 = 1'b1;
                    imm32_de0       = sext_imm12(instr_de0.i.imm_11_0);
                end
                default: begin
                end
            endcase
        end
    end

    // DE1/RD0
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_rd0       <= 1'b0;
            uop_rd0         <= ILLEGAL;
            ifmt_rd0        <= FMT_X;
            funct3_rd0      <= '0;
            rd_rd0          <= '0;
            rs1_rd0         <= '0;
            rs2_rd0         <= '0;
            src2_is_imm_rd0 <= 1'b0;
            imm32_rd0       <= '0;
        end else if (!stall) begin
            // a bubble enters when the queue is empty
            valid_rd0       <= fe_valid_de0;
            uop_rd0         <= uop_de0;
            ifmt_rd0        <= ifmt_de0;
            funct3_rd0      <= funct3_de0;
            rd_rd0          <= rd_de0;
            rs1_rd0         <= rs1_de0;
            rs2_rd0         <= rs2_de0;
            src2_is_imm_rd0 <= src2_is_imm_de0;
            imm32_rd0       <= imm32_de0;
        end
    end

endmodule

`default_nettype wire

/* hdl/instr_queue.sv */
`default_nettype none

module instr_queue
    import rv_decode_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      in_valid,
    input  t_rv_instr in_instr,
    output logic      in_ready,
    input  logic      stall,
    output logic      fe_valid_de0,
    output t_rv_instr instr_de0
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    t_rv_instr        mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    always_comb in_ready     = (count != CNT_W'(QUEUE_DEPTH));
    always_comb fe_valid_de0 = (count != '0);
    // oldest entry goes straight to decode
    always_comb instr_de0    = mem[rd_ptr];

    always_comb push = in_valid & in_ready;
    always_comb pop  = fe_valid_de0 & ~stall;

    // storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_instr;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/rv_decode_pkg.sv */
`default_nettype none

package rv_decode_pkg;

    // register index width fixed by RV32I
    localparam int REG_ADDR_W = 5;

    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        OP_IMM = 7'b0010011,
        AUIPC  = 7'b0010111,
        STORE  = 7'b0100011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JALR   = 7'b1100111,
        JAL    = 7'b1101111
    } t_rv_opcode;

    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_X
    } t_rv_instr_format;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        ILLEGAL
    } t_uop;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        t_rv_opcode            opcode;
    } t_rv_instr_r;

    typedef struct packed {
        logic [11:0]           imm_11_0;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        t_rv_opcode            opcode;
    } t_rv_instr_i;

    // same 32-bit word seen through either layout
    typedef union packed {
        t_rv_instr_r r;
        t_rv_instr_i i;
    } t_rv_instr;

    function automatic t_rv_instr_format get_instr_format(t_rv_opcode opcode);
        t_rv_instr_format ifmt;
        case (opcode)
            OP:                  ifmt = FMT_R;
            OP_IMM, LOAD, JALR:  ifmt = FMT_I;
            STORE:               ifmt = FMT_S;
            BRANCH:              ifmt = FMT_B;
            LUI, AUIPC:          ifmt = FMT_U;
            JAL:                 ifmt = FMT_J;
            default:             ifmt = FMT_X;
        endcase
        return ifmt;
    endfunction

    function automatic t_uop rv_instr_to_uop(t_rv_instr instr);
        t_uop uop;
        logic alt;
        alt = instr.r.funct7[5];
        case (instr.r.funct3)
            3'b000:  uop = ADD;
            3'b001:  uop = SLL;
            3'b010:  uop = SLT;
            3'b011:  uop = SLTU;
            3'b100:  uop = XOR;
            3'b101:  uop = alt ? SRA : SRL;
            3'b110:  uop = OR;
            default: uop = AND;
        endcase
        if (instr.r.opcode == OP) begin
            // only the base and alternate funct7 encodings exist
            if (instr.r.funct7 != 7'b0000000 && instr.r.funct7 != 7'b0100000) begin
                uop = ILLEGAL;
            end else if (instr.r.funct3 == 3'b000 && alt) begin
                uop = SUB;
            end
        end else if (instr.r.opcode != OP_IMM) begin
            uop = ILLEGAL;
        end
        return uop;
    endfunction

    function automatic logic [31:0] sext_imm12(logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

endpackage

`default_nettype wire
